// File: hdl/xosera_pkg.sv
// shared constants for the video controller
// widths, CPU register numbers, interrupt bits and display timing
package xosera_pkg;
    // widths
    localparam int ADDR_W    = 16;      // VRAM word address
    localparam int DATA_W    = 16;      // VRAM word
    localparam int PAL_IDX_W = 4;       // palette index, one pixel
    localparam int RGB_W     = 4;       // one colour component
    localparam int REG_NUM_W = 4;
    localparam int INTR_W    = 4;       // interrupt sources

    // CPU register numbers
    localparam logic [REG_NUM_W-1:0] REG_ADDR     = 4'd0;   // VRAM address
    localparam logic [REG_NUM_W-1:0] REG_DATA     = 4'd1;   // VRAM data, addr++ on write
    localparam logic [REG_NUM_W-1:0] REG_PAL      = 4'd2;   // [15:12] index, [11:0] rgb
    localparam logic [REG_NUM_W-1:0] REG_FILL_VAL = 4'd3;
    localparam logic [REG_NUM_W-1:0] REG_FILL_CNT = 4'd4;   // write starts a fill
    localparam logic [REG_NUM_W-1:0] REG_INTR     = 4'd5;   // [11:8] mask, [3:0] status
    localparam logic [REG_NUM_W-1:0] REG_STATUS   = 4'd6;   // read only

    // interrupt bit positions
    localparam int INTR_VSYNC = 0;
    localparam int INTR_FILL  = 1;

    // display timing, in pixels and lines
    localparam int CLKS_PER_PIX   = 2;
    localparam int VIS_W          = 32;
    localparam int H_TOTAL        = 40;
    localparam int H_SYNC_START   = 34;
    localparam int H_SYNC_LEN     = 3;
    localparam int VIS_H          = 8;
    localparam int V_TOTAL        = 10;
    localparam int V_SYNC_LINE    = 9;
    localparam int PIX_PER_WORD   = 4;  // msb nibble is leftmost
    localparam int WORDS_PER_LINE = 8;
    localparam int FB_BASE        = 0;
endpackage

// File: hdl/vram_if.sv
`timescale 1ns/1ns
// one master's VRAM request, four-phase req/ack
// master holds addr/wr/wdata while req is high
interface vram_if;
    import xosera_pkg::*;

    logic              req;
    logic              ack;     // rdata valid while high
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;

    modport master (
        output req, wr, addr, wdata,
        input  ack, rdata
    );

    modport target (
        input  req, wr, addr, wdata,
        output ack, rdata
    );
endinterface

// File: hdl/vram_array.sv
`timescale 1ns/1ns
// 64K x 16 video RAM, full word writes
// read data registered one cycle after en_i
module vram_array (
    input  wire logic                          clk,
    input  wire logic                          en_i,
    input  wire logic                          wr_i,
    input  wire logic [xosera_pkg::ADDR_W-1:0] addr_i,
    input  wire logic [xosera_pkg::DATA_W-1:0] wdata_i,
    output logic      [xosera_pkg::DATA_W-1:0] rdata_o
);
    import xosera_pkg::*;

    logic [DATA_W-1:0] mem [2**ADDR_W];    // maps to block RAM

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (wr_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];         // old word on a write cycle
        end
    end
endmodule

// File: hdl/vram_arbiter.sv
`timescale 1ns/1ns
// fixed-priority VRAM arbiter for three four-phase masters
// port 0 video (highest), port 1 CPU, port 2 fill
module vram_arbiter (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    vram_if.target                             vid_port,
    vram_if.target                             cpu_port,
    vram_if.target                             fill_port,
    output logic                               mem_en_o,
    output logic                               mem_wr_o,
    output logic      [xosera_pkg::ADDR_W-1:0] mem_addr_o,
    output logic      [xosera_pkg::DATA_W-1:0] mem_wdata_o,
    input  wire logic [xosera_pkg::DATA_W-1:0] mem_rdata_i
);
    import xosera_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,       // choose a requester
        ARB_ACCESS,     // memory cycle
        ARB_ACK,        // ack up, rdata valid
        ARB_WAIT        // ack held until req drops
    } arb_state_t;

    arb_state_t        state;
    logic [1:0]        grant;
    logic [1:0]        pick;
    logic [2:0]        req;
    logic              ack_on;
    logic              wr_a    [3];
    logic [ADDR_W-1:0] addr_a  [3];
    logic [DATA_W-1:0] wdata_a [3];

    assign req        = {fill_port.req, cpu_port.req, vid_port.req};
    assign wr_a[0]    = vid_port.wr;
    assign wr_a[1]    = cpu_port.wr;
    assign wr_a[2]    = fill_port.wr;
    assign addr_a[0]  = vid_port.addr;
    assign addr_a[1]  = cpu_port.addr;
    assign addr_a[2]  = fill_port.addr;
    assign wdata_a[0] = vid_port.wdata;
    assign wdata_a[1] = cpu_port.wdata;
    assign wdata_a[2] = fill_port.wdata;

    assign pick   = req[0] ? 2'd0 : (req[1] ? 2'd1 : 2'd2);
    assign ack_on = (state == ARB_ACK) || (state == ARB_WAIT);

    // granted port steers the memory
    assign mem_en_o    = (state == ARB_ACCESS);
    assign mem_wr_o    = mem_en_o && wr_a[grant];
    assign mem_addr_o  = addr_a[grant];
    assign mem_wdata_o = wdata_a[grant];

    // ack and data only to the granted port
    assign vid_port.ack    = ack_on && (grant == 2'd0);
    assign cpu_port.ack    = ack_on && (grant == 2'd1);
    assign fill_port.ack   = ack_on && (grant == 2'd2);
    assign vid_port.rdata  = (grant == 2'd0) ? mem_rdata_i : '0;
    assign cpu_port.rdata  = (grant == 2'd1) ? mem_rdata_i : '0;
    assign fill_port.rdata = (grant == 2'd2) ? mem_rdata_i : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ARB_IDLE;
            grant <= 2'd0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (|req) begin
                        grant <= pick;      // priority only decided here
                        state <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: state <= ARB_ACK;
                ARB_ACK:    state <= ARB_WAIT;
                default: begin
                    if (!req[grant]) begin
                        state <= ARB_IDLE;  // ack falls with this
                    end
                end
            endcase
        end
    end
endmodule

// File: hdl/bus_regs.sv
`timescale 1ns/1ns
// CPU register block on the 8-bit byte-lane bus
// VRAM address/data access, palette writes, fill start, interrupt mask/status
module bus_regs (
    input  wire logic                             clk,
    input  wire logic                             reset_i,
    input  wire logic                             bus_cs_n_i,     // strobe, active low
    input  wire logic                             bus_rd_nwr_i,   // 1 = read
    input  wire logic [xosera_pkg::REG_NUM_W-1:0] bus_reg_num_i,
    input  wire logic                             bus_bytesel_i,  // 0 = high byte
    input  wire logic [7:0]                       bus_data_i,
    output logic      [7:0]                       bus_data_o,
    output logic                                  bus_intr_o,
    vram_if.master                                cpu_port,
    output logic                                  fill_start_o,   // one-cycle pulse
    output logic      [xosera_pkg::ADDR_W-1:0]    fill_addr_o,
    output logic      [xosera_pkg::DATA_W-1:0]    fill_val_o,
    output logic      [xosera_pkg::DATA_W-1:0]    fill_cnt_o,
    input  wire logic                             fill_busy_i,
    input  wire logic                             fill_done_i,
    input  wire logic                             vsync_start_i,
    output logic                                  pal_wr_o,
    output logic      [xosera_pkg::PAL_IDX_W-1:0] pal_idx_o,
    output logic      [3*xosera_pkg::RGB_W-1:0]   pal_data_o
);
    import xosera_pkg::*;

    logic              cs_n_r1;
    logic              cs_n_r2;
    logic              strobe;      // once per cs low period
    logic              wr_odd;      // odd byte write, acts on the whole word
    logic [7:0]        hi_byte;
    logic [7:0]        rd_byte;
    logic [DATA_W-1:0] wr_word;
    logic [DATA_W-1:0] rd_word;
    logic [ADDR_W-1:0] vram_addr;
    logic [DATA_W-1:0] rd_latch;
    logic              cpu_busy;
    logic [INTR_W-1:0] intr_mask;
    logic [INTR_W-1:0] intr_status;
    logic [INTR_W-1:0] intr_set;
    logic [INTR_W-1:0] intr_clr;

    assign strobe         = !cs_n_r1 && cs_n_r2;
    assign wr_odd         = strobe && !bus_rd_nwr_i && bus_bytesel_i;
    assign wr_word        = {hi_byte, bus_data_i};
    assign bus_data_o     = bus_cs_n_i ? 8'h00 : rd_byte;
    assign intr_clr       = (wr_odd && bus_reg_num_i == REG_INTR) ? wr_word[INTR_W-1:0] : '0;
    assign cpu_port.addr  = vram_addr;

    always_comb begin
        intr_set             = '0;
        intr_set[INTR_VSYNC] = vsync_start_i;
        intr_set[INTR_FILL]  = fill_done_i;
        case (bus_reg_num_i)
            REG_ADDR:     rd_word = vram_addr;
            REG_DATA:     rd_word = rd_latch;
            REG_FILL_VAL: rd_word = fill_val_o;
            REG_FILL_CNT: rd_word = fill_cnt_o;
            REG_INTR:     rd_word = {4'h0, intr_mask, 4'h0, intr_status};
            REG_STATUS:   rd_word = {14'h0, fill_busy_i, cpu_busy};
            default:      rd_word = '0;     // palette is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_r1      <= 1'b1;
            cs_n_r2      <= 1'b1;
            rd_byte      <= 8'h00;
            cpu_busy     <= 1'b0;
            cpu_port.req <= 1'b0;
            fill_start_o <= 1'b0;
            pal_wr_o     <= 1'b0;
            intr_mask    <= '0;
            intr_status  <= '0;
            bus_intr_o   <= 1'b0;
        end else begin
            cs_n_r1      <= bus_cs_n_i;
            cs_n_r2      <= cs_n_r1;
            fill_start_o <= 1'b0;
            pal_wr_o     <= 1'b0;
            intr_status  <= (intr_status | intr_set) & ~intr_clr;   // sticky
            bus_intr_o   <= |(intr_status & intr_mask);
            if (strobe && bus_rd_nwr_i) begin
                rd_byte <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            end else if (cs_n_r1) begin
                rd_byte <= 8'h00;
            end
            // master side of the VRAM handshake
            if (cpu_busy && !cpu_port.req && !cpu_port.ack) begin
                cpu_port.req <= 1'b1;
            end else if (cpu_port.req && cpu_port.ack) begin
                cpu_port.req <= 1'b0;
                cpu_busy     <= 1'b0;
                if (cpu_port.wr) begin
                    vram_addr <= vram_addr + 1'b1;  // auto increment
                end else begin
                    rd_latch <= cpu_port.rdata;
                end
            end
            if (strobe && !bus_rd_nwr_i && !bus_bytesel_i) begin
                hi_byte <= bus_data_i;
            end
            if (wr_odd) begin
                case (bus_reg_num_i)
                    REG_ADDR: begin
                        vram_addr   <= wr_word;
                        cpu_port.wr <= 1'b0;    // read ahead for REG_DATA
                        cpu_busy    <= 1'b1;
                    end
                    REG_DATA: begin
                        cpu_port.wdata <= wr_word;
                        cpu_port.wr    <= 1'b1;
                        cpu_busy       <= 1'b1;
                    end
                    REG_PAL: begin
                        pal_wr_o   <= 1'b1;
                        pal_idx_o  <= wr_word[15:12];
                        pal_data_o <= wr_word[11:0];
                    end
                    REG_FILL_VAL: fill_val_o <= wr_word;
                    REG_FILL_CNT: begin
                        fill_cnt_o   <= wr_word;
                        fill_addr_o  <= vram_addr;  // fill starts at current address
                        fill_start_o <= 1'b1;
                    end
                    REG_INTR: intr_mask <= wr_word[8 +: INTR_W];
                    default: ;
                endcase
            end
        end
    end
endmodule

// File: hdl/fill_engine.sv
`timescale 1ns/1ns
// word fill: writes val_i to cnt_i consecutive VRAM words from addr_i
// one arbiter transfer per word, done_o pulses at the end
module fill_engine (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          start_i,
    input  wire logic [xosera_pkg::ADDR_W-1:0] addr_i,
    input  wire logic [xosera_pkg::DATA_W-1:0] val_i,
    input  wire logic [xosera_pkg::DATA_W-1:0] cnt_i,
    output logic                               busy_o,
    output logic                               done_o,
    vram_if.master                             fill_port
);
    import xosera_pkg::*;

    logic [ADDR_W-1:0] cur_addr;
    logic [DATA_W-1:0] remain;      // words still to write

    assign fill_port.wr    = 1'b1;
    assign fill_port.addr  = cur_addr;
    assign fill_port.wdata = val_i;  // steady while busy

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o        <= 1'b0;
            done_o        <= 1'b0;
            fill_port.req <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !busy_o) begin
                cur_addr <= addr_i;
                remain   <= cnt_i;
                busy_o   <= (cnt_i != '0);
                done_o   <= (cnt_i == '0);   // empty fill ends at once
            end else if (busy_o && !fill_port.req && !fill_port.ack) begin
                fill_port.req <= 1'b1;
            end else if (fill_port.req && fill_port.ack) begin
                fill_port.req <= 1'b0;
                cur_addr      <= cur_addr + 1'b1;
                remain        <= remain - 1'b1;
                if (remain == DATA_W'(1)) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end
endmodule

// File: hdl/video_scan.sv
`timescale 1ns/1ns
// display timing and bitmap fetch, 4 bits per pixel
// fetches the word one 4-pixel group ahead and outputs the current nibble
module video_scan (
    input  wire logic                             clk,
    input  wire logic                             reset_i,
    vram_if.master                                vid_port,
    output logic      [xosera_pkg::PAL_IDX_W-1:0] pix_idx_o,
    output logic                                  hsync_o,
    output logic                                  vsync_o,
    output logic                                  de_o,
    output logic                                  vsync_start_o
);
    import xosera_pkg::*;

    localparam int DIV_W = $clog2(CLKS_PER_PIX);
    localparam int H_W   = $clog2(H_TOTAL);
    localparam int V_W   = $clog2(V_TOTAL);
    localparam int GRP_W = $clog2(PIX_PER_WORD);

    logic [DIV_W-1:0]  pix_div;
    logic [H_W-1:0]    h_cnt;
    logic [V_W-1:0]    v_cnt;
    logic              pix_last;    // last clock of a pixel
    logic              grp_end;     // last clock of a group
    logic [H_W:0]      f_h;         // first pixel of the group after next
    logic [V_W:0]      f_v;
    logic              f_vis;
    logic [ADDR_W-1:0] f_addr;
    logic [DATA_W-1:0] fetch_word;
    logic [DATA_W-1:0] disp_word;   // word being shown

    assign pix_last = (pix_div == DIV_W'(CLKS_PER_PIX - 1));
    assign grp_end  = pix_last && (h_cnt[GRP_W-1:0] == '1);

    always_comb begin
        f_h = {1'b0, h_cnt} + (H_W+1)'(PIX_PER_WORD + 1);
        f_v = {1'b0, v_cnt};
        if (f_h >= (H_W+1)'(H_TOTAL)) begin     // wraps into next line
            f_h = f_h - (H_W+1)'(H_TOTAL);
            f_v = (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : f_v + 1'b1;
        end
    end
    assign f_vis  = (f_h < (H_W+1)'(VIS_W)) && (f_v < (V_W+1)'(VIS_H));
    assign f_addr = ADDR_W'(FB_BASE + f_v * WORDS_PER_LINE + f_h / PIX_PER_WORD);

    assign vid_port.wr    = 1'b0;
    assign vid_port.wdata = '0;
    assign pix_idx_o      = disp_word[(PIX_PER_WORD-1-h_cnt[GRP_W-1:0])*PAL_IDX_W +: PAL_IDX_W];
    assign de_o           = (h_cnt < H_W'(VIS_W)) && (v_cnt < V_W'(VIS_H));
    assign hsync_o        = (h_cnt >= H_W'(H_SYNC_START)) &&
                            (h_cnt < H_W'(H_SYNC_START + H_SYNC_LEN));
    assign vsync_o        = (v_cnt == V_W'(V_SYNC_LINE));
    assign vsync_start_o  = vsync_o && (h_cnt == '0) && (pix_div == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_div      <= '0;
            h_cnt        <= '0;
            v_cnt        <= '0;
            vid_port.req <= 1'b0;
        end else begin
            pix_div <= pix_last ? '0 : pix_div + 1'b1;
            if (pix_last) begin
                h_cnt <= (h_cnt == H_W'(H_TOTAL - 1)) ? '0 : h_cnt + 1'b1;
                if (h_cnt == H_W'(H_TOTAL - 1)) begin
                    v_cnt <= (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                end
            end
            if (grp_end) begin
                disp_word <= fetch_word;    // next group starts now
                if (f_vis) begin
                    vid_port.req  <= 1'b1;
                    vid_port.addr <= f_addr;
                end
            end else if (vid_port.req && vid_port.ack) begin
                vid_port.req <= 1'b0;
                fetch_word   <= vid_port.rdata;
            end
        end
    end
endmodule

// File: hdl/palette_out.sv
`timescale 1ns/1ns
// 16 x 12 palette and registered RGB output stage
// sync and de delayed one cycle to line up with the colour
module palette_out (
    input  wire logic                             clk,
    input  wire logic                             reset_i,
    input  wire logic                             pal_wr_i,
    input  wire logic [xosera_pkg::PAL_IDX_W-1:0] pal_idx_wr_i,
    input  wire logic [3*xosera_pkg::RGB_W-1:0]   pal_data_i,
    input  wire logic [xosera_pkg::PAL_IDX_W-1:0] pix_idx_i,
    input  wire logic                             hsync_i,
    input  wire logic                             vsync_i,
    input  wire logic                             de_i,
    output logic      [xosera_pkg::RGB_W-1:0]     red_o,
    output logic      [xosera_pkg::RGB_W-1:0]     green_o,
    output logic      [xosera_pkg::RGB_W-1:0]     blue_o,
    output logic                                  hsync_o,
    output logic                                  vsync_o,
    output logic                                  dv_de_o
);
    import xosera_pkg::*;

    logic [3*RGB_W-1:0] pal [2**PAL_IDX_W];
    logic [3*RGB_W-1:0] color;

    assign color = de_i ? pal[pix_idx_i] : '0;     // black in blanking

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal[pal_idx_wr_i] <= pal_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            {red_o, green_o, blue_o} <= '0;
            hsync_o                  <= 1'b0;
            vsync_o                  <= 1'b0;
            dv_de_o                  <= 1'b0;
        end else begin
            {red_o, green_o, blue_o} <= color;
            hsync_o                  <= hsync_i;
            vsync_o                  <= vsync_i;
            dv_de_o                  <= de_i;
        end
    end
endmodule

// File: hdl/xosera_top.sv
`timescale 1ns/1ns
// top level of the video controller
// CPU byte bus in, RGB and sync out, all blocks share one VRAM
module xosera_top (
    input  wire logic                             clk,
    input  wire logic                             reset_i,
    input  wire logic                             bus_cs_n_i,
    input  wire logic                             bus_rd_nwr_i,
    input  wire logic [xosera_pkg::REG_NUM_W-1:0] bus_reg_num_i,
    input  wire logic                             bus_bytesel_i,
    input  wire logic [7:0]                       bus_data_i,
    output logic      [7:0]                       bus_data_o,
    output logic                                  bus_intr_o,
    output logic      [xosera_pkg::RGB_W-1:0]     red_o,
    output logic      [xosera_pkg::RGB_W-1:0]     green_o,
    output logic      [xosera_pkg::RGB_W-1:0]     blue_o,
    output logic                                  hsync_o,
    output logic                                  vsync_o,
    output logic                                  dv_de_o
);
    import xosera_pkg::*;

    vram_if vid_if ();
    vram_if cpu_if ();
    vram_if fill_if ();

    logic                 mem_en;
    logic                 mem_wr;
    logic [ADDR_W-1:0]    mem_addr;
    logic [DATA_W-1:0]    mem_wdata;
    logic [DATA_W-1:0]    mem_rdata;
    logic                 fill_start;
    logic [ADDR_W-1:0]    fill_addr;
    logic [DATA_W-1:0]    fill_val;
    logic [DATA_W-1:0]    fill_cnt;
    logic                 fill_busy;
    logic                 fill_done;
    logic                 vsync_start;
    logic                 pal_wr;
    logic [PAL_IDX_W-1:0] pal_idx;
    logic [3*RGB_W-1:0]   pal_data;
    logic [PAL_IDX_W-1:0] pix_idx;
    logic                 raw_hsync;   // before the palette stage
    logic                 raw_vsync;
    logic                 raw_de;

    bus_regs bus_regs_inst (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o, .bus_intr_o,
        .cpu_port(cpu_if.master),
        .fill_start_o(fill_start), .fill_addr_o(fill_addr), .fill_val_o(fill_val),
        .fill_cnt_o(fill_cnt), .fill_busy_i(fill_busy), .fill_done_i(fill_done),
        .vsync_start_i(vsync_start),
        .pal_wr_o(pal_wr), .pal_idx_o(pal_idx), .pal_data_o(pal_data)
    );

    fill_engine fill_engine_inst (
        .clk, .reset_i, .start_i(fill_start), .addr_i(fill_addr), .val_i(fill_val),
        .cnt_i(fill_cnt), .busy_o(fill_busy), .done_o(fill_done),
        .fill_port(fill_if.master)
    );

    video_scan video_scan_inst (
        .clk, .reset_i, .vid_port(vid_if.master), .pix_idx_o(pix_idx),
        .hsync_o(raw_hsync), .vsync_o(raw_vsync), .de_o(raw_de),
        .vsync_start_o(vsync_start)
    );

    vram_arbiter vram_arbiter_inst (
        .clk, .reset_i,
        .vid_port(vid_if.target), .cpu_port(cpu_if.target), .fill_port(fill_if.target),
        .mem_en_o(mem_en), .mem_wr_o(mem_wr), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
    );

    vram_array vram_array_inst (
        .clk, .en_i(mem_en), .wr_i(mem_wr), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

    palette_out palette_out_inst (
        .clk, .reset_i, .pal_wr_i(pal_wr), .pal_idx_wr_i(pal_idx), .pal_data_i(pal_data),
        .pix_idx_i(pix_idx), .hsync_i(raw_hsync), .vsync_i(raw_vsync), .de_i(raw_de),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .dv_de_o
    );
endmodule

// File: tb/tb_xosera.sv
`timescale 1ns/1ns
// directed testbench for the video controller top level
// drives the CPU byte bus, watches RGB/sync output, checks against a local VRAM/palette model
module tb_xosera;
    import xosera_pkg::*;

    localparam int  FRAME_CLKS = V_TOTAL * H_TOTAL * CLKS_PER_PIX;
    localparam real WATCH_NS   = 20.0 * FRAME_CLKS * 100.0;    // 20 frames

    logic                 clk;
    logic                 reset_i;
    logic                 bus_cs_n_i;
    logic                 bus_rd_nwr_i;
    logic [REG_NUM_W-1:0] bus_reg_num_i;
    logic                 bus_bytesel_i;
    logic [7:0]           bus_data_i;
    logic [7:0]           bus_data_o;
    logic                 bus_intr_o;
    logic [RGB_W-1:0]     red_o, green_o, blue_o;
    logic                 hsync_o, vsync_o, dv_de_o;

    logic [31:0]          rng = 32'h87d923bb;
    logic [DATA_W-1:0]    fb [VIS_H*WORDS_PER_LINE];     // expected framebuffer
    logic [3*RGB_W-1:0]   pal_model [2**PAL_IDX_W];
    int                   errors = 0;
    int                   tests = 0;
    int                   de_pix;                         // de-high pixels in last frame

    xosera_top xosera_top_inst (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] next_random();
        rng = xorshift(rng);
        return rng[15:0];
    endfunction

    task automatic check(input logic [31:0] exp, input logic [31:0] act, input string msg);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s, expected %h got %h", $time, msg, exp, act);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    // one cs low period that returns the byte on bus_data_o before cs rises
    task automatic bus_strobe(input logic rd, input logic [3:0] rnum, input logic sel,
                              input logic [7:0] d, output logic [7:0] q);
        @(posedge clk);
        #5;
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = rnum;
        bus_bytesel_i = sel;
        bus_data_i    = d;
        repeat (3) @(posedge clk);     // strobe acted on 2nd edge
        #5;
        q          = bus_data_o;
        bus_cs_n_i = 1'b1;
        @(posedge clk);                // cs high long enough for next falling edge
    endtask

    task automatic bus_write(input logic [3:0] rnum, input logic [15:0] word);
        logic [7:0] dummy;
        bus_strobe(1'b0, rnum, 1'b0, word[15:8], dummy);   // high byte latched
        bus_strobe(1'b0, rnum, 1'b1, word[7:0], dummy);    // acts here
    endtask

    task automatic bus_read(input logic [3:0] rnum, output logic [15:0] word);
        bus_strobe(1'b1, rnum, 1'b0, 8'h00, word[15:8]);
        bus_strobe(1'b1, rnum, 1'b1, 8'h00, word[7:0]);
    endtask

    task automatic wait_cpu_idle;
        logic [15:0] s;
        do bus_read(REG_STATUS, s); while (s[0]);
    endtask

    task automatic set_addr(input logic [15:0] a);
        bus_write(REG_ADDR, a);
        wait_cpu_idle();               // read-ahead done
    endtask

    task automatic write_data(input logic [15:0] w);
        bus_write(REG_DATA, w);
        wait_cpu_idle();
    endtask

    task automatic read_vram(input logic [15:0] a, output logic [15:0] w);
        set_addr(a);
        bus_read(REG_DATA, w);
    endtask

    task automatic start_fill(input logic [15:0] a, input logic [15:0] n, input logic [15:0] v);
        bus_write(REG_INTR, 16'h000F);  // mask off, clear status
        bus_write(REG_FILL_VAL, v);
        set_addr(a);
        bus_write(REG_FILL_CNT, n);
    endtask

    task automatic wait_fill_done;
        logic [15:0] r;
        do bus_read(REG_INTR, r); while (!r[INTR_FILL]);
    endtask

    task automatic expect_vram(input logic [15:0] a, input logic [15:0] exp, input string msg);
        logic [15:0] w;
        read_vram(a, w);
        check(32'(exp), 32'(w), msg);
    endtask

    // checks one frame from a vsync rise at each falling clock edge
    task automatic check_frame;
        int          col;
        int          line;
        int          k;
        int          h;
        logic [15:0] w;
        logic [3:0]  nib;
        col    = 0;
        line   = 0;
        k      = 0;
        de_pix = 0;
        @(posedge vsync_o);
        repeat (FRAME_CLKS) begin
            @(negedge clk);
            h = (k / CLKS_PER_PIX) % H_TOTAL;     // pixel position from the vsync rise
            check(32'(h >= H_SYNC_START && h < H_SYNC_START + H_SYNC_LEN), 32'(hsync_o),
                  "hsync");
            check(32'(k < H_TOTAL * CLKS_PER_PIX), 32'(vsync_o), "vsync");  // sync line first
            k++;
            if (dv_de_o) begin
                if (col % CLKS_PER_PIX == 0) begin
                    w   = fb[line * WORDS_PER_LINE + (col / CLKS_PER_PIX) / PIX_PER_WORD];
                    nib = w[(PIX_PER_WORD - 1 - (col / CLKS_PER_PIX) % PIX_PER_WORD) * 4 +: 4];
                    check(32'(pal_model[nib]), 32'({red_o, green_o, blue_o}), "pixel colour");
                    de_pix++;
                end
                col++;
            end else begin
                if (col != 0) begin
                    line++;            // end of a visible line
                    col = 0;
                end
                check(32'd0, 32'({red_o, green_o, blue_o}), "rgb in blanking");
            end
        end
    endtask

    task automatic test_vram_rw;
        logic [15:0] a, w, r;
        for (int i = 0; i < 6; i++) begin
            a = 16'h2000 | (next_random() & 16'h0FFF);
            w = next_random();
            set_addr(a);
            write_data(w);
            expect_vram(a, w, "vram read-back");
        end
        a = 16'h3000;
        set_addr(a);
        write_data(16'h1234);
        write_data(16'hABCD);          // lands at a+1 by auto increment
        bus_read(REG_ADDR, r);
        check(32'(a + 16'd2), 32'(r), "address after two writes");
        expect_vram(a, 16'h1234, "auto increment word 0");
        expect_vram(a + 16'd1, 16'hABCD, "auto increment word 1");
        test_done("vram write/read");
    endtask

    task automatic test_fill;
        logic [15:0] a, n, v;
        a = 16'h4010;
        n = 16'd8;
        v = next_random();
        set_addr(a - 16'd1);
        write_data(16'h5A5A);          // guard words
        set_addr(a + n);
        write_data(16'hA5A5);
        start_fill(a, n, v);
        wait_fill_done();
        expect_vram(a - 16'd1, 16'h5A5A, "word before fill");
        for (int i = 0; i < 8; i++) expect_vram(a + 16'(i), v, "filled word");
        expect_vram(a + n, 16'hA5A5, "word after fill");
        test_done("fill");
    endtask

    task automatic load_display;
        logic [15:0] w;
        for (int i = 0; i < 2**PAL_IDX_W; i++) begin
            w            = next_random();
            pal_model[i] = w[11:0];
            bus_write(REG_PAL, {4'(i), w[11:0]});
        end
        set_addr(16'(FB_BASE));
        for (int i = 0; i < VIS_H * WORDS_PER_LINE; i++) begin
            fb[i] = next_random();
            write_data(fb[i]);
        end
    endtask

    task automatic test_interrupts;
        logic [15:0] r;
        bus_write(REG_INTR, 16'h000F);
        @(posedge vsync_o);
        repeat (H_TOTAL * CLKS_PER_PIX) begin
            @(negedge clk);
            check(32'd0, 32'(bus_intr_o), "intr with mask zero");
        end
        bus_write(REG_INTR, 16'h0100 | 16'h000F);   // vsync mask, clear stale status
        repeat (3) @(negedge clk);
        check(32'd0, 32'(bus_intr_o), "intr before vsync");
        @(posedge vsync_o);
        repeat (4) @(negedge clk);
        check(32'd1, 32'(bus_intr_o), "intr after vsync");
        bus_write(REG_INTR, 16'h010F);
        repeat (3) @(negedge clk);
        check(32'd0, 32'(bus_intr_o), "intr after clear");
        bus_read(REG_INTR, r);
        check(32'h0100, 32'(r), "intr register read");
        bus_write(REG_INTR, 16'h000F);
        test_done("interrupts");
    endtask

    task automatic test_contention;
        logic [15:0] v;
        logic [15:0] n;
        logic [15:0] cw [4];
        v = next_random();
        n = 16'd400;                   // outlasts the wait for vsync plus one frame
        set_addr(16'h5000 + n);
        write_data(16'h3C3C);          // guard after fill
        start_fill(16'h5000, n, v);
        fork
            check_frame();
            begin
                set_addr(16'h6000);
                for (int i = 0; i < 4; i++) begin
                    cw[i] = next_random();
                    write_data(cw[i]);
                end
            end
        join
        check(32'(VIS_W * VIS_H), 32'(de_pix), "de pixels under load");
        wait_fill_done();
        for (int i = 0; i < int'(n); i += 37) begin
            expect_vram(16'h5000 + 16'(i), v, "fill under load");
        end
        expect_vram(16'h5000 + n - 16'd1, v, "last fill word");
        expect_vram(16'h5000 + n, 16'h3C3C, "guard after long fill");
        for (int i = 0; i < 4; i++) expect_vram(16'h6000 + 16'(i), cw[i], "cpu word under load");
        test_done("contention");
    endtask

    initial begin
        #(WATCH_NS);
        $display("simulation timed out before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        repeat (16) @(posedge clk);
        #5;
        reset_i = 1'b0;
        test_vram_rw();
        test_fill();
        load_display();
        check_frame();
        test_done("display");
        check(32'(VIS_W * VIS_H), 32'(de_pix), "de pixels per frame");
        test_done("blanking");
        test_interrupts();
        test_contention();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

// File: compile.f
hdl/xosera_pkg.sv
hdl/vram_if.sv
hdl/vram_array.sv
hdl/vram_arbiter.sv
hdl/bus_regs.sv
hdl/fill_engine.sv
hdl/video_scan.sv
hdl/palette_out.sv
hdl/xosera_top.sv
tb/tb_xosera.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_xosera -f compile.f -o sim_tb_xosera
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_xosera)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
